/* list.f */
logic/ads_pkg.sv
logic/ads_cmd_seq.sv
logic/ads_spi_engine.sv
logic/ads_sample_packer.sv
logic/ads_adc_ctrl.sv
test/adc_spi_model.sv
test/tb_ads_adc_ctrl.sv

/* Bender.yml */
package:
  name: ads_adc_ctrl

sources:
  - files:
      - logic/ads_pkg.sv
      - logic/ads_cmd_seq.sv
      - logic/ads_spi_engine.sv
      - logic/ads_sample_packer.sv
      - logic/ads_adc_ctrl.sv
  - target: test
    files:
      - test/adc_spi_model.sv
      - test/tb_ads_adc_ctrl.sv

/* test/tb_ads_adc_ctrl.sv */
`timescale 1ns/1ps

module tb_ads_adc_ctrl
  import ads_pkg::*;
();

  localparam logic [31:0] SEED = 32'h8ea7470d;
  localparam int MODEL_ID     = 8;
  localparam int CS_HIGH      = cs_high_cycles(MODEL_ID);
  localparam int FRAME_CYCLES = CS_HIGH + 18;         // Upper bound for one SPI frame
  localparam int READ_CYCLES  = 9 * FRAME_CYCLES;
  localparam int BOOT_CYCLES  = 3 * FRAME_CYCLES;
  localparam int READ_DELAY   = 20;
  localparam int LONG_DELAY   = 4000;                 // Only ended by cancel
  localparam int SHORT_DELAY  = 10;
  localparam int NUM_TESTS    = 8;
  localparam int NUM_READS    = 6;                    // ADC reads and read-long quiet windows
  localparam int DELAY_SUM    = 2 * READ_DELAY + LONG_DELAY + SHORT_DELAY;
  localparam int WATCHDOG_CYCLES = DELAY_SUM + NUM_READS * READ_CYCLES
                                   + NUM_TESTS * (BOOT_CYCLES + 200);

  // Status signals that tests wait on
  localparam int SIG_SETUP_DONE = 0;
  localparam int SIG_BOOT_FAIL  = 1;
  localparam int SIG_WAITING    = 2;
  localparam int SIG_UNDERFLOW  = 3;
  localparam int SIG_OVERFLOW   = 4;
  localparam int SIG_BAD_CMD    = 5;

  logic       clk = 1'b0;
  logic       resetn;
  logic       cmd_word_rd_en;
  cmd_word_t  cmd_word;
  logic       cmd_buf_empty;
  logic       data_word_wr_en;
  data_word_t data_word;
  logic       data_buf_full;
  logic       trigger;
  logic       waiting_for_trig;
  logic       setup_done;
  logic       boot_fail;
  logic       cmd_buf_underflow;
  logic       data_buf_overflow;
  logic       unexp_trig;
  logic       bad_cmd;
  logic       n_cs;
  logic       mosi;
  logic       miso;
  logic       bad_readback;    // ADC model knob

  cmd_word_t  cmd_q[$];        // Command buffer contents, head first
  data_word_t exp_q[$];        // Data words still expected
  int         errors;
  int         tests_run;
  int         tests_failed;
  int         test_err_start;
  int         reads_issued;    // Read index for the reference samples
  string      cur_test;

  always #2 clk = ~clk;        // 4 ns period

  ads_adc_ctrl #(
    .ads_model_id (MODEL_ID)
  ) ads_adc_ctrl_inst (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_word_rd_en    (cmd_word_rd_en),
    .cmd_word          (cmd_word),
    .cmd_buf_empty     (cmd_buf_empty),
    .data_word_wr_en   (data_word_wr_en),
    .data_word         (data_word),
    .data_buf_full     (data_buf_full),
    .trigger           (trigger),
    .waiting_for_trig  (waiting_for_trig),
    .setup_done        (setup_done),
    .boot_fail         (boot_fail),
    .cmd_buf_underflow (cmd_buf_underflow),
    .data_buf_overflow (data_buf_overflow),
    .unexp_trig        (unexp_trig),
    .bad_cmd           (bad_cmd),
    .n_cs              (n_cs),
    .mosi              (mosi),
    .miso              (miso)
  );

  adc_spi_model adc_spi_model_inst (
    .clk          (clk),
    .resetn       (resetn),
    .bad_readback (bad_readback),
    .n_cs         (n_cs),
    .mosi         (mosi),
    .miso         (miso)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Reference sample for a channel in the n-th read since reset
  function automatic sample_t sample_value(input chan_t ch, input int read_index);
    logic [31:0] s;
    s = SEED;
    repeat (read_index * 8 + int'(ch) + 1) s = xorshift32(s);
    return s[15:0];
  endfunction

  // Opcode, trigger bit, continue bit, two spare bits, delay
  function automatic cmd_word_t make_cmd(input cmd_op_t op, input logic trig,
                                         input logic cont, input delay_t delay);
    return {op, trig, cont, 2'b00, delay};
  endfunction

  function automatic logic signal_level(input int sig_id);
    case (sig_id)
      SIG_SETUP_DONE: return setup_done;
      SIG_BOOT_FAIL:  return boot_fail;
      SIG_WAITING:    return waiting_for_trig;
      SIG_UNDERFLOW:  return cmd_buf_underflow;
      SIG_OVERFLOW:   return data_buf_overflow;
      default:        return bad_cmd;
    endcase
  endfunction

  task automatic check_data(input data_word_t exp, input data_word_t act);
    if (act !== exp) begin
      $display("Error %s: data word expected %h, actual %h", cur_test, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error %s: %s expected %b, actual %b", cur_test, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flags(input logic exp_setup, input logic exp_boot,
                             input logic exp_under, input logic exp_over,
                             input logic exp_unexp, input logic exp_bad);
    check_flag("setup_done", exp_setup, setup_done);
    check_flag("boot_fail", exp_boot, boot_fail);
    check_flag("cmd_buf_underflow", exp_under, cmd_buf_underflow);
    check_flag("data_buf_overflow", exp_over, data_buf_overflow);
    check_flag("unexp_trig", exp_unexp, unexp_trig);
    check_flag("bad_cmd", exp_bad, bad_cmd);
  endtask

  // Outputs sit at their reset values while resetn is low
  task automatic check_reset_state();
    check_flag("n_cs", 1'b1, n_cs);
    check_flag("cmd_word_rd_en", 1'b0, cmd_word_rd_en);
    check_flag("data_word_wr_en", 1'b0, data_word_wr_en);
    check_flag("waiting_for_trig", 1'b0, waiting_for_trig);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    resetn        <= 1'b0;
    trigger       <= 1'b0;
    data_buf_full <= 1'b0;
    repeat (7) @(posedge clk);
    @(negedge clk);              // Buffers emptied away from the sampling edge
    cmd_q.delete();
    exp_q.delete();
    reads_issued = 0;
    check_reset_state();
    @(posedge clk);
    resetn <= 1'b1;              // Low for 8 rising edges
  endtask

  task automatic wait_signal(input int sig_id, input string what, input int limit);
    int n;
    n = 0;
    while (signal_level(sig_id) !== 1'b1 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (signal_level(sig_id) !== 1'b1) begin
      $display("%s: %s never went high within %0d cycles", cur_test, what, limit);
      errors++;
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d data words never arrived", cur_test, exp_q.size());
      errors++;
    end
  endtask

  task automatic boot();
    apply_reset();
    wait_signal(SIG_SETUP_DONE, "setup_done", BOOT_CYCLES + 50);
  endtask

  task automatic push_cmd(input cmd_word_t cmd);
    @(negedge clk);
    cmd_q.push_back(cmd);
  endtask

  // Queues the command and, if data is due, its four reference words
  task automatic push_adc_read(input delay_t delay, input logic expect_data);
    int k;
    @(negedge clk);
    if (expect_data) begin
      for (k = 0; k < NUM_CHANNELS / 2; k++) begin
        exp_q.push_back({sample_value(chan_t'(2 * k + 1), reads_issued),
                         sample_value(chan_t'(2 * k), reads_issued)});
      end
    end
    reads_issued++;
    cmd_q.push_back(make_cmd(CMD_ADC_READ, 1'b0, 1'b0, delay));
  endtask

  task automatic pulse_trigger();
    @(posedge clk);
    trigger <= 1'b1;
    @(posedge clk);
    trigger <= 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == test_err_start) begin
      $display("%-12s passed", cur_test);
    end else begin
      $display("%-12s failed, %0d errors", cur_test, errors - test_err_start);
      tests_failed++;
    end
  endtask

  // Show-ahead command buffer with the head updated after each pop
  always @(posedge clk) begin : cmd_buffer
    if (cmd_word_rd_en && cmd_q.size() > 0) cmd_q.delete(0);
    if (cmd_q.size() > 0) begin
      cmd_word      <= cmd_q[0];
      cmd_buf_empty <= 1'b0;
    end else begin
      cmd_word      <= '0;
      cmd_buf_empty <= 1'b1;
    end
  end

  // Every data buffer write must match the next reference word
  always @(posedge clk) begin : data_monitor
    data_word_t exp_word;
    if (resetn && data_word_wr_en) begin
      if (exp_q.size() == 0) begin
        $display("Error %s: data word %h written with none expected", cur_test, data_word);
        errors++;
      end else begin
        exp_word = exp_q.pop_front();
        check_data(exp_word, data_word);
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    resetn        = 1'b0;
    cmd_word      = '0;
    cmd_buf_empty = 1'b1;
    data_buf_full = 1'b0;
    trigger       = 1'b0;
    bad_readback  = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    reads_issued  = 0;

    start_test("boot_ok");
    boot();
    check_flags(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end_test();

    start_test("boot_fail");
    @(posedge clk);
    bad_readback <= 1'b1;                // Readback byte comes back as zero
    apply_reset();
    wait_signal(SIG_BOOT_FAIL, "boot_fail", BOOT_CYCLES + 50);
    repeat (20) @(posedge clk);
    check_flags(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    bad_readback <= 1'b0;
    end_test();

    start_test("adc_read");
    boot();
    push_adc_read(delay_t'(READ_DELAY), 1'b1);
    push_adc_read(delay_t'(READ_DELAY), 1'b1);  // Second read uses the next sample set
    wait_drained(2 * READ_CYCLES + 50);
    repeat (50) @(posedge clk);
    check_flags(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end_test();

    start_test("trig_wait");
    boot();
    push_cmd(make_cmd(CMD_WAIT, 1'b1, 1'b0, '0));
    wait_signal(SIG_WAITING, "waiting_for_trig", 50);
    pulse_trigger();
    repeat (5) @(posedge clk);
    check_flag("waiting_for_trig", 1'b0, waiting_for_trig);
    check_flags(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    pulse_trigger();                     // Nobody waits for this one
    repeat (5) @(posedge clk);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    end_test();

    start_test("cancel");
    boot();
    push_cmd(make_cmd(CMD_WAIT, 1'b0, 1'b0, delay_t'(LONG_DELAY)));
    push_cmd(make_cmd(CMD_CANCEL, 1'b0, 1'b0, '0));
    push_adc_read('0, 1'b1);
    wait_drained(READ_CYCLES + 50);      // Far shorter than the cancelled delay
    repeat (50) @(posedge clk);
    check_flags(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end_test();

    start_test("underflow");
    boot();
    push_cmd(make_cmd(CMD_WAIT, 1'b0, 1'b1, delay_t'(SHORT_DELAY)));
    wait_signal(SIG_UNDERFLOW, "cmd_buf_underflow", SHORT_DELAY + 50);
    push_adc_read('0, 1'b0);             // Must be ignored after the error
    repeat (READ_CYCLES) @(posedge clk);
    check_flags(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    end_test();

    start_test("bad_cmd");
    boot();
    push_cmd(make_cmd(CMD_RESERVED, 1'b0, 1'b0, '0));
    wait_signal(SIG_BAD_CMD, "bad_cmd", 50);
    push_adc_read('0, 1'b0);
    repeat (READ_CYCLES) @(posedge clk);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    end_test();

    start_test("overflow");
    boot();
    @(posedge clk);
    data_buf_full <= 1'b1;               // Any write would be lost
    push_adc_read('0, 1'b0);
    wait_signal(SIG_OVERFLOW, "data_buf_overflow", READ_CYCLES + 50);
    repeat (50) @(posedge clk);
    check_flags(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    @(posedge clk);
    data_buf_full <= 1'b0;
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* test/adc_spi_model.sv */
`timescale 1ns/1ps

module adc_spi_model
  import ads_pkg::*;
(
  input  logic clk,
  input  logic resetn,
  input  logic bad_readback,  // Answer the boot readback with zero
  input  logic n_cs,
  input  logic mosi,
  output logic miso
);

  localparam logic [31:0] SEED = 32'h8ea7470d;

  spi_frame_t rx;       // MOSI bits of the running frame
  logic [4:0] nbits;    // Bits seen in the running frame
  sample_t    tx;       // Answer to the previous request
  logic [3:0] req_cnt;  // Sample request within one read, 0..8
  int         reads;    // Completed read sequences

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Sample stream, one xorshift step per channel slot
  function automatic sample_t sample_value(input chan_t ch, input int read_index);
    logic [31:0] s;
    s = SEED;
    repeat (read_index * 8 + int'(ch) + 1) s = xorshift32(s);
    return s[15:0];
  endfunction

  always @(posedge clk) begin
    if (!resetn) begin
      nbits   <= '0;
      tx      <= '0;
      req_cnt <= '0;
      reads   <= 0;
      miso    <= 1'b0;
    end else if (!n_cs) begin
      rx    <= {rx[22:0], mosi};  // Controller sends MSB first
      nbits <= nbits + 1'b1;
      miso  <= (nbits < 5'd15) ? tx[5'd14 - nbits] : 1'b0;  // Next bit for the next edge
    end else begin
      miso <= tx[15];              // First bit ready before n_cs falls
      if (nbits != '0) begin
        nbits <= '0;
        // Frame just ended, work out the answer for the next one
        if (nbits == 5'd24 && rx[23:19] == SPI_CMD_REG_READ && rx[18:8] == ADDR_OTF_CFG) begin
          tx <= {(bad_readback ? 8'h00 : OTF_CFG_ENABLE), 8'h00};
        end else if (nbits == 5'd16 && rx[15:14] == 2'b10) begin
          tx <= sample_value(chan_t'(rx[13:11]), reads);  // On-the-fly channel request
          if (req_cnt == 4'd8) begin
            req_cnt <= '0;
            reads   <= reads + 1;
          end else begin
            req_cnt <= req_cnt + 1'b1;
          end
        end else begin
          tx <= '0;
        end
      end
    end
  end

endmodule

/* logic/ads_adc_ctrl.sv */
`timescale 1ns/1ps

module ads_adc_ctrl
  import ads_pkg::*;
#(
  parameter int ads_model_id = 8  // 8, 7 or 6 for ADS8168, ADS8167, ADS8166
) (
  input  logic       clk,
  input  logic       resetn,
  output logic       cmd_word_rd_en,
  input  cmd_word_t  cmd_word,
  input  logic       cmd_buf_empty,
  output logic       data_word_wr_en,
  output data_word_t data_word,
  input  logic       data_buf_full,
  input  logic       trigger,
  output logic       waiting_for_trig,
  output logic       setup_done,
  output logic       boot_fail,
  output logic       cmd_buf_underflow,
  output logic       data_buf_overflow,
  output logic       unexp_trig,
  output logic       bad_cmd,
  output logic       n_cs,
  output logic       mosi,
  input  logic       miso
);

  localparam logic [7:0] cs_high_time = cs_high_cycles(ads_model_id);

  logic       start_frame;
  spi_frame_t frame_word;
  logic       frame_long;
  logic       capture_en;
  logic       frame_done;
  logic       sample_valid;
  sample_t    sample;
  logic       run_sample_valid;
  logic       flush;
  logic       overflow;

  ads_cmd_seq ads_cmd_seq_inst (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_word          (cmd_word),
    .cmd_buf_empty     (cmd_buf_empty),
    .cmd_word_rd_en    (cmd_word_rd_en),
    .trigger           (trigger),
    .waiting_for_trig  (waiting_for_trig),
    .setup_done        (setup_done),
    .boot_fail         (boot_fail),
    .cmd_buf_underflow (cmd_buf_underflow),
    .data_buf_overflow (data_buf_overflow),
    .unexp_trig        (unexp_trig),
    .bad_cmd           (bad_cmd),
    .start_frame       (start_frame),
    .frame_word        (frame_word),
    .frame_long        (frame_long),
    .capture_en        (capture_en),
    .frame_done        (frame_done),
    .sample_valid      (sample_valid),
    .sample            (sample),
    .run_sample_valid  (run_sample_valid),
    .flush             (flush),
    .overflow          (overflow)
  );

  ads_spi_engine ads_spi_engine_inst (
    .clk          (clk),
    .resetn       (resetn),
    .cs_high_time (cs_high_time),
    .start_frame  (start_frame),
    .frame_word   (frame_word),
    .frame_long   (frame_long),
    .capture_en   (capture_en),
    .frame_done   (frame_done),
    .sample_valid (sample_valid),
    .sample       (sample),
    .n_cs         (n_cs),
    .mosi         (mosi),
    .miso         (miso)
  );

  ads_sample_packer ads_sample_packer_inst (
    .clk              (clk),
    .resetn           (resetn),
    .run_sample_valid (run_sample_valid),
    .sample           (sample),
    .flush            (flush),
    .data_buf_full    (data_buf_full),
    .data_word_wr_en  (data_word_wr_en),
    .data_word        (data_word),
    .overflow         (overflow)
  );

endmodule

/* logic/ads_sample_packer.sv */
`timescale 1ns/1ps

module ads_sample_packer
  import ads_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  logic       run_sample_valid,
  input  sample_t    sample,
  input  logic       flush,
  input  logic       data_buf_full,
  output logic       data_word_wr_en,
  output data_word_t data_word,
  output logic       overflow
);

  sample_t first_q;      // Even channel waiting for its partner
  logic    have_first;
  logic    try_write;

  assign try_write       = run_sample_valid && have_first && !flush;
  assign overflow        = try_write && data_buf_full;   // Word dropped
  assign data_word       = {sample, first_q};            // First sample in the low half

  always_ff @(posedge clk) begin
    if (!resetn || flush)  have_first <= 1'b0;
    else if (run_sample_valid) have_first <= !have_first;
  end

  always_ff @(posedge clk) begin
    if (run_sample_valid && !have_first) first_q <= sample;
  end

  // A full buffer loses the write without a stall
  assign data_word_wr_en = try_write && !data_buf_full;

  // A lost word stops the controller on the next cycle
  assert property (@(posedge clk) disable iff (!resetn)
    overflow |=> flush);

endmodule

/* logic/ads_spi_engine.sv */
`timescale 1ns/1ps

module ads_spi_engine
  import ads_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  logic [7:0] cs_high_time,
  input  logic       start_frame,
  input  spi_frame_t frame_word,
  input  logic       frame_long,
  input  logic       capture_en,
  output logic       frame_done,
  output logic       sample_valid,
  output sample_t    sample,
  output logic       n_cs,
  output logic       mosi,
  input  logic       miso
);

  logic [7:0] cs_timer;     // Conversion time left
  logic       cs_wait;      // n_cs held high before the bits
  logic       long_q;       // 24-bit frame
  logic       cap_q;        // Capture MISO in this frame
  logic [4:0] bit_cnt;      // Bit being transferred
  logic [4:0] last_bit;
  logic       cs_release;
  spi_frame_t mosi_sr;
  sample_t    miso_sr;

  assign last_bit   = long_q ? 5'd23 : 5'd15;
  assign cs_release = cs_wait && (cs_timer <= 8'd1);    // Last high cycle
  assign frame_done = !n_cs && (bit_cnt == last_bit);   // Last bit cycle
  assign mosi       = !n_cs && mosi_sr[23];             // Quiet between frames
  assign sample     = miso_sr;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cs_timer <= '0;
      cs_wait  <= 1'b0;
    end else if (start_frame) begin
      cs_timer <= cs_high_time;
      cs_wait  <= 1'b1;
    end else begin
      if (cs_timer != '0) cs_timer <= cs_timer - 1'b1;
      if (cs_release)     cs_wait  <= 1'b0;
    end
  end

  // Frame shape, taken at the start pulse
  always_ff @(posedge clk) begin
    if (!resetn) begin
      long_q <= 1'b0;
      cap_q  <= 1'b0;
    end else if (start_frame) begin
      long_q <= frame_long;
      cap_q  <= capture_en;
    end
  end

  // One bit per clk while n_cs is low
  always_ff @(posedge clk) begin
    if (!resetn) begin
      n_cs    <= 1'b1;
      bit_cnt <= '0;
    end else if (cs_release) begin
      n_cs    <= 1'b0;
      bit_cnt <= '0;
    end else if (!n_cs) begin
      if (frame_done) begin
        n_cs    <= 1'b1;
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_frame) mosi_sr <= frame_word;
    else if (!n_cs)  mosi_sr <= {mosi_sr[22:0], 1'b0};  // MSB first
  end

  // Only the first 16 bits carry data
  always_ff @(posedge clk) begin
    if (!n_cs && cap_q && bit_cnt < 5'd16) miso_sr <= {miso_sr[14:0], miso};
  end

  always_ff @(posedge clk) begin
    if (!resetn) sample_valid <= 1'b0;
    else         sample_valid <= !n_cs && cap_q && (bit_cnt == 5'd15);
  end

  // n_cs low only inside a frame's bit window
  assert property (@(posedge clk) disable iff (!resetn)
    !n_cs |-> (bit_cnt <= last_bit) && !cs_wait);

  // Sequencer waits for the previous frame before starting the next
  assert property (@(posedge clk) disable iff (!resetn)
    start_frame |-> n_cs && !cs_wait);

endmodule

/* logic/ads_cmd_seq.sv */
`timescale 1ns/1ps

module ads_cmd_seq
  import ads_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  cmd_word_t  cmd_word,
  input  logic       cmd_buf_empty,
  output logic       cmd_word_rd_en,
  input  logic       trigger,
  output logic       waiting_for_trig,
  output logic       setup_done,
  output logic       boot_fail,
  output logic       cmd_buf_underflow,
  output logic       data_buf_overflow,
  output logic       unexp_trig,
  output logic       bad_cmd,
  output logic       start_frame,
  output spi_frame_t frame_word,
  output logic       frame_long,
  output logic       capture_en,
  input  logic       frame_done,
  input  logic       sample_valid,
  input  sample_t    sample,
  output logic       run_sample_valid,
  output logic       flush,
  input  logic       overflow
);

  typedef enum logic [3:0] {
    S_RESET, S_BOOT_WR, S_REQ_RD, S_READBACK, S_IDLE,
    S_DELAY, S_TRIG_WAIT, S_ADC_RD, S_ERROR
  } seq_state_t;

  seq_state_t state;
  seq_state_t next_state;
  cmd_op_t    op;             // Opcode of the buffer head
  logic       wait_trig;      // Trigger bit of the running command
  logic       expect_next;    // Continue bit of the running command
  delay_t     delay_timer;
  logic [3:0] frame_idx;      // Read frame 0..8
  logic       frames_done;    // Ninth read frame finished
  logic       cmd_done;
  logic       cancel_wait;
  logic       accept;
  logic       underflow;
  logic       readback_ok;
  logic       readback_bad;
  logic       trig_err;
  logic       op_err;
  logic       error;
  logic       issue_frame;
  spi_frame_t issue_word;
  logic       issue_long;
  logic       issue_cap;
  chan_t      next_chan;

  function automatic spi_frame_t reg_write_frame(input logic [10:0] addr, input logic [7:0] data);
    return {SPI_CMD_REG_WRITE, addr, data};
  endfunction

  function automatic spi_frame_t reg_read_frame(input logic [10:0] addr);
    return {SPI_CMD_REG_READ, addr, 8'd0};
  endfunction

  // On-the-fly sample request in the upper 16 bits of the frame
  function automatic spi_frame_t otf_sample_frame(input chan_t ch);
    return {2'b10, ch, 11'd0, 8'd0};
  endfunction

  assign op = cmd_op(cmd_word);

  // Current command has finished its wait
  always_comb begin
    case (state)
      S_IDLE:      cmd_done = !cmd_buf_empty;
      S_DELAY:     cmd_done = (delay_timer == '0);
      S_TRIG_WAIT: cmd_done = trigger;
      S_ADC_RD:    cmd_done = frames_done && !wait_trig && (delay_timer == '0);
      default:     cmd_done = 1'b0;
    endcase
  end

  assign cancel_wait = (state == S_DELAY || state == S_TRIG_WAIT
                        || (state == S_ADC_RD && frames_done))
                       && !cmd_buf_empty && (op == CMD_CANCEL);
  assign accept    = cmd_done && !cmd_buf_empty;
  assign underflow = cmd_done && cmd_buf_empty && expect_next;  // Promised command missing

  assign readback_ok  = (state == S_READBACK) && sample_valid && (sample[15:8] == OTF_CFG_ENABLE);
  assign readback_bad = (state == S_READBACK) && sample_valid && (sample[15:8] != OTF_CFG_ENABLE);
  assign trig_err     = trigger && (state != S_TRIG_WAIT);
  assign op_err       = accept && (op == CMD_RESERVED);
  assign error        = readback_bad || trig_err || op_err || underflow || overflow;

  assign cmd_word_rd_en   = accept || cancel_wait;
  assign waiting_for_trig = (state == S_TRIG_WAIT);
  assign run_sample_valid = sample_valid && (state != S_READBACK);  // Readback stays here
  assign flush            = (state == S_ERROR);

  always_comb begin
    next_state = state;
    if (error) begin
      next_state = S_ERROR;
    end else begin
      case (state)
        S_RESET:    next_state = S_BOOT_WR;
        S_BOOT_WR:  if (frame_done) next_state = S_REQ_RD;
        S_REQ_RD:   if (frame_done) next_state = S_READBACK;
        S_READBACK: if (readback_ok) next_state = S_IDLE;
        S_ERROR:    next_state = S_ERROR;  // Left only by reset
        default: begin
          if (cancel_wait) begin
            next_state = S_IDLE;
          end else if (accept) begin
            case (op)
              CMD_WAIT:     next_state = cmd_word[TRIG_BIT] ? S_TRIG_WAIT : S_DELAY;
              CMD_ADC_READ: next_state = S_ADC_RD;
              default:      next_state = S_IDLE;  // Cancel with nothing to cancel
            endcase
          end else if (cmd_done) begin
            next_state = S_IDLE;  // Buffer empty and nothing promised
          end else if (state == S_ADC_RD && frames_done && wait_trig) begin
            next_state = S_TRIG_WAIT;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) state <= S_RESET;
    else         state <= next_state;
  end

  always_ff @(posedge clk) begin
    if (!resetn || state == S_ERROR) begin
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (cancel_wait) begin
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (accept) begin
      if (op == CMD_WAIT || op == CMD_ADC_READ) begin
        wait_trig   <= cmd_word[TRIG_BIT];
        expect_next <= cmd_word[CONT_BIT];
      end else begin
        wait_trig   <= 1'b0;
        expect_next <= 1'b0;
      end
    end
  end

  // Delay counts from acceptance and runs on across the read frames
  always_ff @(posedge clk) begin
    if (!resetn || state == S_ERROR || cancel_wait) begin
      delay_timer <= '0;
    end else if (accept && (op == CMD_WAIT || op == CMD_ADC_READ)) begin
      delay_timer <= cmd_word[TRIG_BIT] ? '0 : cmd_delay(cmd_word);
    end else if (delay_timer != '0) begin
      delay_timer <= delay_timer - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || state == S_ERROR) begin
      frame_idx   <= '0;
      frames_done <= 1'b0;
    end else if (accept && op == CMD_ADC_READ) begin
      frame_idx   <= '0;
      frames_done <= 1'b0;
    end else if (state == S_ADC_RD && frame_done) begin
      if (frame_idx == NUM_CHANNELS) frames_done <= 1'b1;
      else                           frame_idx   <= frame_idx + 1'b1;
    end
  end

  // Frame k asks for channel k and frame 8 wraps to channel 0
  assign next_chan = chan_t'(frame_idx + 4'd1);

  always_comb begin
    issue_frame = 1'b0;
    issue_word  = '0;
    issue_long  = 1'b0;
    issue_cap   = 1'b0;
    case (state)
      S_RESET: begin
        issue_frame = 1'b1;
        issue_word  = reg_write_frame(ADDR_OTF_CFG, OTF_CFG_ENABLE);
        issue_long  = 1'b1;
      end
      S_BOOT_WR: begin
        issue_frame = frame_done;
        issue_word  = reg_read_frame(ADDR_OTF_CFG);
        issue_long  = 1'b1;
      end
      S_REQ_RD: begin
        issue_frame = frame_done;  // No-op frame while the register value comes back on MISO
        issue_cap   = 1'b1;
      end
      S_ADC_RD: begin
        issue_frame = frame_done && (frame_idx != NUM_CHANNELS);
        issue_word  = otf_sample_frame(next_chan);
        issue_cap   = 1'b1;        // Returns the previous channel
      end
      default: ;
    endcase
    if (accept && op == CMD_ADC_READ) begin
      issue_frame = 1'b1;
      issue_word  = otf_sample_frame('0);
      issue_long  = 1'b0;
      issue_cap   = 1'b0;          // Nothing converted yet
    end
    if (error) issue_frame = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      start_frame <= 1'b0;
      frame_long  <= 1'b0;
      capture_en  <= 1'b0;
    end else begin
      start_frame <= issue_frame;
      if (issue_frame) begin
        frame_long <= issue_long;
        capture_en <= issue_cap;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_frame) frame_word <= issue_word;  // Held through the frame
  end

  always_ff @(posedge clk) begin
    if (!resetn || state == S_ERROR) setup_done <= 1'b0;
    else if (readback_ok)            setup_done <= 1'b1;
  end

  // Sticky error flags
  always_ff @(posedge clk) begin
    if (!resetn) begin
      boot_fail         <= 1'b0;
      cmd_buf_underflow <= 1'b0;
      data_buf_overflow <= 1'b0;
      unexp_trig        <= 1'b0;
      bad_cmd           <= 1'b0;
    end else begin
      if (readback_bad) boot_fail         <= 1'b1;
      if (underflow)    cmd_buf_underflow <= 1'b1;
      if (overflow)     data_buf_overflow <= 1'b1;
      if (trig_err)     unexp_trig        <= 1'b1;
      if (op_err)       bad_cmd           <= 1'b1;
    end
  end

  // Samples only come back while a state is there to take them
  assert property (@(posedge clk) disable iff (!resetn)
    sample_valid |-> state inside {S_READBACK, S_ADC_RD, S_ERROR});

endmodule

/* logic/ads_pkg.sv */
package ads_pkg;

  // Data widths with a meaning of their own
  typedef logic [31:0] cmd_word_t;   // One entry of the command buffer
  typedef logic [31:0] data_word_t;  // Two samples, first one in [15:0]
  typedef logic [15:0] sample_t;     // ADC sample or register readback
  typedef logic [23:0] spi_frame_t;  // MOSI frame, MSB first
  typedef logic [25:0] delay_t;      // Delay count in clk cycles
  typedef logic [2:0]  chan_t;       // ADC input channel

  // Opcode in command bits 31..30
  typedef enum logic [1:0] {
    CMD_WAIT     = 2'd0,  // Delay or trigger wait
    CMD_ADC_READ = 2'd1,  // Read all channels
    CMD_RESERVED = 2'd2,  // Not supported, reported as bad command
    CMD_CANCEL   = 2'd3   // Ends a pending wait
  } cmd_op_t;

  localparam int TRIG_BIT = 29;  // Wait for trigger instead of delay
  localparam int CONT_BIT = 28;  // Another command must follow

  // ADC register access over SPI
  localparam logic [4:0]  SPI_CMD_REG_WRITE = 5'd1;
  localparam logic [4:0]  SPI_CMD_REG_READ  = 5'd2;
  localparam logic [10:0] ADDR_OTF_CFG      = 11'h2A;  // On-the-fly config register
  localparam logic [7:0]  OTF_CFG_ENABLE    = 8'h01;   // Turns on-the-fly mode on

  localparam int NUM_CHANNELS = 8;

  function automatic cmd_op_t cmd_op(input cmd_word_t cmd);
    return cmd_op_t'(cmd[31:30]);
  endfunction

  function automatic delay_t cmd_delay(input cmd_word_t cmd);
    return delay_t'(cmd[25:0]);
  endfunction

  // Minimum n_cs high time per model, max of conversion time and cycle time less 16 bits
  function automatic logic [7:0] cs_high_cycles(input int model_id);
    case (model_id)
      8:       return 8'd34;   // ADS8168
      7:       return 8'd84;   // ADS8167
      default: return 8'd184;  // ADS8166 and anything unknown
    endcase
  endfunction

endpackage
